// ==== logic/bus_pkg.sv ====
package bus_pkg;

	// ============================================================
	// Bus widths shared by the masters, the bridge and the decoder
	// ============================================================

	// Bits per byte of bus data
	parameter int BPB = 8;

	// Width of a master address
	parameter int ADR_W = 24;

	// Top nibble that marks an address as belonging to the I/O range
	parameter logic [3:0] IO_TAG = 4'hE;

	// One bus address
	typedef logic [ADR_W-1:0] bus_adr_t;

	// One byte of bus data
	typedef logic [BPB-1:0] bus_dat_t;

endpackage

// ==== logic/io_map_pkg.sv ====
package io_map_pkg;

	import bus_pkg::*;

	// ============================================================
	// I/O device address map
	// ============================================================

	// Scratch RAM, 16 bytes from E00000 up to E0000F
	parameter bus_adr_t RAM_BASE = 24'hE00000;

	// GPIO register block, two registers
	parameter bus_adr_t GPIO_BASE = 24'hE00100;

	// Output register, writable and reads back
	parameter logic [3:0] GPIO_OUT_OFS = 4'd0;
	// Input pins register, read only
	parameter logic [3:0] GPIO_IN_OFS = 4'd1;

	// Data returned for an I/O address that no device claims
	parameter bus_dat_t FILL_DAT = 8'hFF;

endpackage

// ==== logic/io_bridge.sv ====
`timescale 1ns/100ps

module io_bridge import bus_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_i,
	// Port 1 is the CPU and wins every tie
	input  logic     s1_cyc_i,
	input  logic     s1_stb_i,
	input  logic     s1_we_i,
	input  bus_adr_t s1_adr_i,
	input  bus_dat_t s1_dat_i,
	output logic     s1_ack_o,
	output bus_dat_t s1_dat_o,
	// Port 2 is the second master, for example a DMA engine
	input  logic     s2_cyc_i,
	input  logic     s2_stb_i,
	input  logic     s2_we_i,
	input  bus_adr_t s2_adr_i,
	input  bus_dat_t s2_dat_i,
	output logic     s2_ack_o,
	output bus_dat_t s2_dat_o,
	// Registered master bus toward the I/O decoder
	output logic     m_cyc_o,
	output logic     m_stb_o,
	output logic     m_we_o,
	output bus_adr_t m_adr_o,
	output bus_dat_t m_dat_o,
	input  logic     m_ack_i,
	input  bus_dat_t m_dat_i
);

	typedef enum logic [1:0] {
		IDLE,
		WAIT_ACK,
		WAIT_NACK
	} state_t;

	state_t state;
	// Zero when port 1 owns the current access, one for port 2
	logic   which;
	// Internal ack, one cycle ahead of the port ack
	logic   s_ack;
	logic   s1_req;
	logic   s2_req;
	logic   win_cyc;
	logic   win_stb;

	// Only requests into the I/O range are seen at all
	assign s1_req = s1_cyc_i & s1_stb_i & (s1_adr_i[ADR_W-1 -: 4] == IO_TAG);
	assign s2_req = s2_cyc_i & s2_stb_i & (s2_adr_i[ADR_W-1 -: 4] == IO_TAG);

	// Cycle and strobe of whichever port owns the access
	assign win_cyc = which ? s2_cyc_i : s1_cyc_i;
	assign win_stb = which ? s2_stb_i : s1_stb_i;

	// ============================================================
	// Return path acks
	// ============================================================

	// The port ack follows s_ack by a cycle and falls as soon as
	// the owning port lets go of its strobe
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			s1_ack_o <= 1'b0;
			s2_ack_o <= 1'b0;
		end else begin
			s1_ack_o <= s_ack & s1_stb_i & ~which;
			s2_ack_o <= s_ack & s2_stb_i & which;
		end
	end

	// ============================================================
	// Control FSM
	// ============================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state   <= IDLE;
			which   <= 1'b0;
			s_ack   <= 1'b0;
			m_cyc_o <= 1'b0;
			m_stb_o <= 1'b0;
			m_we_o  <= 1'b0;
		end else begin
			case (state)
			IDLE: begin
				// A device still acking the last access holds us off
				if (!m_ack_i && (s1_req || s2_req)) begin
					which   <= ~s1_req;
					m_cyc_o <= 1'b1;
					m_stb_o <= 1'b1;
					m_we_o  <= s1_req ? s1_we_i : s2_we_i;
					state   <= WAIT_ACK;
				end
			end
			WAIT_ACK: begin
				// Owner dropped cyc, so the access is abandoned
				if (!win_cyc) begin
					m_cyc_o <= 1'b0;
					m_stb_o <= 1'b0;
					m_we_o  <= 1'b0;
					state   <= IDLE;
				end else if (m_ack_i) begin
					s_ack <= 1'b1;
					state <= WAIT_NACK;
				end
			end
			WAIT_NACK: begin
				// Hold everything until the owner drops its strobe
				if (!win_stb) begin
					m_cyc_o <= 1'b0;
					m_stb_o <= 1'b0;
					m_we_o  <= 1'b0;
					s_ack   <= 1'b0;
					state   <= IDLE;
				end
			end
			default: state <= IDLE;
			endcase
		end
	end

	// ============================================================
	// Address and data registers
	// ============================================================

	always_ff @(posedge clk_i) begin
		// Upper nibble is forced to E so devices see a fixed range
		if (state == IDLE && !m_ack_i) begin
			if (s1_req) begin
				m_adr_o <= {IO_TAG, s1_adr_i[ADR_W-5:0]};
				m_dat_o <= s1_dat_i;
			end else if (s2_req) begin
				m_adr_o <= {IO_TAG, s2_adr_i[ADR_W-5:0]};
				m_dat_o <= s2_dat_i;
			end
		end
		// Read data is caught together with the device ack
		if (state == WAIT_ACK && win_cyc && m_ack_i) begin
			if (which)
				s2_dat_o <= m_dat_i;
			else
				s1_dat_o <= m_dat_i;
		end
		// Owner's data goes back to zero when it releases the strobe
		if (state == WAIT_NACK && !win_stb) begin
			if (which)
				s2_dat_o <= '0;
			else
				s1_dat_o <= '0;
		end
	end

endmodule

// ==== logic/io_decoder.sv ====
`timescale 1ns/100ps

module io_decoder import bus_pkg::*, io_map_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	// Master bus from the bridge
	input  logic       m_cyc_i,
	input  logic       m_stb_i,
	input  logic       m_we_i,
	input  bus_adr_t   m_adr_i,
	input  bus_dat_t   m_dat_i,
	output logic       m_ack_o,
	output bus_dat_t   m_dat_o,
	// Device side
	input  logic       ram_ack_i,
	input  bus_dat_t   ram_dat_i,
	input  logic       gpio_ack_i,
	input  bus_dat_t   gpio_dat_i,
	output logic       ram_sel_o,
	output logic       gpio_sel_o,
	output logic       dev_we_o,
	output logic [3:0] dev_adr_o,
	output bus_dat_t   dev_dat_o
);

	logic io_hit;
	logic ram_hit;
	logic gpio_hit;
	logic fill_ack;

	// RAM claims a 16-byte window, GPIO only its two registers
	assign io_hit   = (m_adr_i[ADR_W-1 -: 4] == IO_TAG);
	assign ram_hit  = (m_adr_i[ADR_W-1:4] == RAM_BASE[ADR_W-1:4]);
	assign gpio_hit = (m_adr_i[ADR_W-1:1] == GPIO_BASE[ADR_W-1:1]);

	assign ram_sel_o  = m_cyc_i & ram_hit;
	assign gpio_sel_o = m_cyc_i & gpio_hit;

	// Devices share the low address bits, we and write data
	assign dev_we_o  = m_we_i;
	assign dev_adr_o = m_adr_i[3:0];
	assign dev_dat_o = m_dat_i;

	// Unclaimed I/O addresses are answered here a cycle after strobe
	// and released a cycle after strobe falls, like a real device
	always_ff @(posedge clk_i) begin
		if (rst_i)
			fill_ack <= 1'b0;
		else
			fill_ack <= m_cyc_i & m_stb_i & io_hit & ~ram_hit & ~gpio_hit;
	end

	assign m_ack_o = ram_ack_i | gpio_ack_i | fill_ack;

	// Return data follows whichever source is acking
	always_comb begin
		if (ram_ack_i)
			m_dat_o = ram_dat_i;
		else if (gpio_ack_i)
			m_dat_o = gpio_dat_i;
		else if (fill_ack)
			m_dat_o = FILL_DAT;
		else
			m_dat_o = '0;
	end

endmodule

// ==== logic/io_scratch_ram.sv ====
`timescale 1ns/100ps

module io_scratch_ram import bus_pkg::*; #(
	parameter int RAM_DEPTH = 16
) (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       sel_i,
	input  logic       stb_i,
	input  logic       we_i,
	input  logic [3:0] adr_i,
	input  bus_dat_t   dat_i,
	output logic       ack_o,
	output bus_dat_t   dat_o
);

	localparam int AW = $clog2(RAM_DEPTH);

	bus_dat_t mem [RAM_DEPTH];
	logic     first;

	// True only on the cycle whose edge raises the ack
	assign first = sel_i & stb_i & ~ack_o;

	always_ff @(posedge clk_i) begin
		if (rst_i)
			ack_o <= 1'b0;
		else
			ack_o <= sel_i & stb_i;
	end

	// One write per access even though strobe is held for several cycles
	always_ff @(posedge clk_i) begin
		if (first && we_i)
			mem[adr_i[AW-1:0]] <= dat_i;
		if (first && !we_i)
			dat_o <= mem[adr_i[AW-1:0]];
	end

endmodule

// ==== logic/io_gpio.sv ====
`timescale 1ns/100ps

module io_gpio import bus_pkg::*, io_map_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       sel_i,
	input  logic       stb_i,
	input  logic       we_i,
	input  logic [3:0] adr_i,
	input  bus_dat_t   dat_i,
	input  bus_dat_t   gpio_in_i,
	output logic       ack_o,
	output bus_dat_t   dat_o,
	output bus_dat_t   gpio_out_o
);

	// Two-flop synchronizer on the input pins
	bus_dat_t in_meta;
	bus_dat_t in_sync;

	always_ff @(posedge clk_i) begin
		in_meta <= gpio_in_i;
		in_sync <= in_meta;
	end

	// Ack and output register, writes to the input offset fall through
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_o      <= 1'b0;
			gpio_out_o <= '0;
		end else begin
			ack_o <= sel_i & stb_i;
			if (sel_i && stb_i && we_i && adr_i == GPIO_OUT_OFS)
				gpio_out_o <= dat_i;
		end
	end

	always_ff @(posedge clk_i) begin
		case (adr_i)
		GPIO_OUT_OFS: dat_o <= gpio_out_o;
		GPIO_IN_OFS:  dat_o <= in_sync;
		default:      dat_o <= FILL_DAT;
		endcase
	end

endmodule

// ==== logic/io_subsys_top.sv ====
`timescale 1ns/100ps

module io_subsys_top import bus_pkg::*; #(
	parameter int RAM_DEPTH = 16
) (
	input  logic     clk_i,
	input  logic     rst_i,
	input  logic     s1_cyc_i,
	input  logic     s1_stb_i,
	input  logic     s1_we_i,
	input  bus_adr_t s1_adr_i,
	input  bus_dat_t s1_dat_i,
	output logic     s1_ack_o,
	output bus_dat_t s1_dat_o,
	input  logic     s2_cyc_i,
	input  logic     s2_stb_i,
	input  logic     s2_we_i,
	input  bus_adr_t s2_adr_i,
	input  bus_dat_t s2_dat_i,
	output logic     s2_ack_o,
	output bus_dat_t s2_dat_o,
	input  bus_dat_t gpio_in_i,
	output bus_dat_t gpio_out_o
);

	// ============================================================
	// Internal master bus and device wiring
	// ============================================================

	logic       m_cyc;
	logic       m_stb;
	logic       m_we;
	bus_adr_t   m_adr;
	bus_dat_t   m_dat_o;
	logic       m_ack;
	bus_dat_t   m_dat_i;
	logic       ram_sel;
	logic       gpio_sel;
	logic       dev_we;
	logic [3:0] dev_adr;
	bus_dat_t   dev_dat;
	logic       ram_ack;
	bus_dat_t   ram_dat;
	logic       gpio_ack;
	bus_dat_t   gpio_dat;

	io_bridge u_bridge (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.s1_cyc_i (s1_cyc_i),
		.s1_stb_i (s1_stb_i),
		.s1_we_i  (s1_we_i),
		.s1_adr_i (s1_adr_i),
		.s1_dat_i (s1_dat_i),
		.s1_ack_o (s1_ack_o),
		.s1_dat_o (s1_dat_o),
		.s2_cyc_i (s2_cyc_i),
		.s2_stb_i (s2_stb_i),
		.s2_we_i  (s2_we_i),
		.s2_adr_i (s2_adr_i),
		.s2_dat_i (s2_dat_i),
		.s2_ack_o (s2_ack_o),
		.s2_dat_o (s2_dat_o),
		.m_cyc_o  (m_cyc),
		.m_stb_o  (m_stb),
		.m_we_o   (m_we),
		.m_adr_o  (m_adr),
		.m_dat_o  (m_dat_o),
		.m_ack_i  (m_ack),
		.m_dat_i  (m_dat_i)
	);

	io_decoder u_decoder (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.m_cyc_i    (m_cyc),
		.m_stb_i    (m_stb),
		.m_we_i     (m_we),
		.m_adr_i    (m_adr),
		.m_dat_i    (m_dat_o),
		.m_ack_o    (m_ack),
		.m_dat_o    (m_dat_i),
		.ram_ack_i  (ram_ack),
		.ram_dat_i  (ram_dat),
		.gpio_ack_i (gpio_ack),
		.gpio_dat_i (gpio_dat),
		.ram_sel_o  (ram_sel),
		.gpio_sel_o (gpio_sel),
		.dev_we_o   (dev_we),
		.dev_adr_o  (dev_adr),
		.dev_dat_o  (dev_dat)
	);

	io_scratch_ram #(
		.RAM_DEPTH (RAM_DEPTH)
	) u_ram (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.sel_i (ram_sel),
		.stb_i (m_stb),
		.we_i  (dev_we),
		.adr_i (dev_adr),
		.dat_i (dev_dat),
		.ack_o (ram_ack),
		.dat_o (ram_dat)
	);

	io_gpio u_gpio (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.sel_i      (gpio_sel),
		.stb_i      (m_stb),
		.we_i       (dev_we),
		.adr_i      (dev_adr),
		.dat_i      (dev_dat),
		.gpio_in_i  (gpio_in_i),
		.ack_o      (gpio_ack),
		.dat_o      (gpio_dat),
		.gpio_out_o (gpio_out_o)
	);

endmodule

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen #(
	parameter real PERIOD     = 40.0,
	parameter int  RST_CYCLES = 8
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2.0) clk_o = ~clk_o;
	end

	// Reset is released a little after an edge so that it never races the clock
	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		#2;
		rst_o = 1'b0;
	end

endmodule

// ==== tb/io_bridge_asserts.sv ====
`timescale 1ns/100ps

module io_bridge_asserts (
	input logic clk_i,
	input logic rst_i,
	input logic s1_stb_i,
	input logic s2_stb_i,
	input logic s1_ack_o,
	input logic s2_ack_o,
	input logic m_cyc_o,
	input logic m_stb_o
);

	// Running count of failed properties
	int fail_count = 0;

	// Only one port may own the bridge at a time
	one_ack_only: assert property (@(posedge clk_i) disable iff (rst_i)
		!(s1_ack_o && s2_ack_o))
		else begin
			fail_count++;
			$error("both port acks are high together");
		end

	// A strobe on the internal bus always sits inside a cycle
	stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		m_stb_o |-> m_cyc_o)
		else begin
			fail_count++;
			$error("m_stb is high without m_cyc");
		end

	// An ack only answers a strobe that was already held at the two edges before it
	s1_ack_stb: assert property (@(posedge clk_i) disable iff (rst_i)
		s1_ack_o |-> $past(s1_stb_i) && $past(s1_stb_i, 2))
		else begin
			fail_count++;
			$error("port 1 ack is high without its strobe");
		end

	s2_ack_stb: assert property (@(posedge clk_i) disable iff (rst_i)
		s2_ack_o |-> $past(s2_stb_i) && $past(s2_stb_i, 2))
		else begin
			fail_count++;
			$error("port 2 ack is high without its strobe");
		end

endmodule

bind io_bridge io_bridge_asserts u_bridge_asserts (
	.clk_i    (clk_i),
	.rst_i    (rst_i),
	.s1_stb_i (s1_stb_i),
	.s2_stb_i (s2_stb_i),
	.s1_ack_o (s1_ack_o),
	.s2_ack_o (s2_ack_o),
	.m_cyc_o  (m_cyc_o),
	.m_stb_o  (m_stb_o)
);

// ==== tb/io_subsys_tb.sv ====
`timescale 1ns/100ps

module io_subsys_tb import bus_pkg::*, io_map_pkg::*; ();

	localparam int MAX_LINES = 64;
	localparam int ACK_LIMIT = 8;

	logic     clk;
	logic     rst;
	logic     s1_cyc, s1_stb, s1_we, s1_ack;
	logic     s2_cyc, s2_stb, s2_we, s2_ack;
	bus_adr_t s1_adr, s2_adr;
	bus_dat_t s1_wdat, s2_wdat, s1_rdat, s2_rdat;
	bus_dat_t gpio_in, gpio_out;

	// Parsed stim lines
	int         n_lines;
	int         st_port [MAX_LINES];
	logic [7:0] st_op   [MAX_LINES];
	bus_adr_t   st_adr  [MAX_LINES];
	bus_dat_t   st_wdat [MAX_LINES];
	bus_dat_t   st_exp  [MAX_LINES];

	int cycles;
	int cycle_limit;
	int checks;
	int errors;

	tb_clkgen #(.PERIOD(40.0), .RST_CYCLES(8)) u_clkgen (.clk_o(clk), .rst_o(rst));

	io_subsys_top #(.RAM_DEPTH(16)) dut0 (
		.clk_i (clk), .rst_i (rst),
		.s1_cyc_i (s1_cyc), .s1_stb_i (s1_stb), .s1_we_i (s1_we),
		.s1_adr_i (s1_adr), .s1_dat_i (s1_wdat), .s1_ack_o (s1_ack), .s1_dat_o (s1_rdat),
		.s2_cyc_i (s2_cyc), .s2_stb_i (s2_stb), .s2_we_i (s2_we),
		.s2_adr_i (s2_adr), .s2_dat_i (s2_wdat), .s2_ack_o (s2_ack), .s2_dat_o (s2_rdat),
		.gpio_in_i (gpio_in), .gpio_out_o (gpio_out)
	);

	// ============================================================
	// Cycle counter and run limit
	// ============================================================

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout: the run passed %0d cycles without finishing", cycle_limit);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input bus_dat_t exp, input bus_dat_t act);
		checks++;
		assert (act === exp)
		else begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_true(input string name, input bit cond, input string what);
		checks++;
		assert (cond)
		else begin
			errors++;
			$display("%s: %s", name, what);
		end
	endtask

	task automatic drive_port(input int port, input logic cyc, input logic we,
			input bus_adr_t adr, input bus_dat_t dat);
		if (port == 1) begin
			s1_cyc = cyc;
			s1_stb = cyc;
			s1_we = we;
			s1_adr = adr;
			s1_wdat = dat;
		end else begin
			s2_cyc = cyc;
			s2_stb = cyc;
			s2_we = we;
			s2_adr = adr;
			s2_wdat = dat;
		end
	endtask

	// Called 2 ns after an edge, returns 2 ns after a later edge
	task automatic run_access(input int port, input logic we, input bus_adr_t adr,
			input bus_dat_t wd, input int limit, output bit acked,
			output bus_dat_t rd, output int ack_cyc);
		bit ack_now;
		int i;
		acked = 0;
		rd = '0;
		ack_cyc = 0;
		drive_port(port, 1'b1, we, adr, wd);
		for (i = 0; i < limit && !acked; i++) begin
			@(posedge clk);
			#1;
			ack_now = (port == 1) ? s1_ack : s2_ack;
			if (ack_now) begin
				acked = 1;
				rd = (port == 1) ? s1_rdat : s2_rdat;
				ack_cyc = cycles;
			end
		end
		#1;
		drive_port(port, 1'b0, 1'b0, '0, '0);
		// Ack must be gone within 2 cycles of the strobe falling
		repeat (2) @(posedge clk);
		#1;
		ack_now = (port == 1) ? s1_ack : s2_ack;
		check_true("release", !ack_now, "ack stayed high after the strobe fell");
		#1;
	endtask

	// ============================================================
	// Stimulus replay
	// ============================================================

	initial begin
		int fd;
		int n;
		int i;
		int p;
		int c1;
		int c2;
		int asserts_failed;
		bit a1;
		bit a2;
		bit seen;
		bus_dat_t r1;
		bus_dat_t r2;
		bus_dat_t pins;
		string line;
		string name;

		void'($urandom(32'hf474_5a34));
		cycles = 0;
		cycle_limit = 0;
		checks = 0;
		errors = 0;
		drive_port(1, 1'b0, 1'b0, '0, '0);
		drive_port(2, 1'b0, 1'b0, '0, '0);
		gpio_in = '0;

		n_lines = 0;
		fd = $fopen("tb/io_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stim file tb/io_stim.txt");
			errors++;
		end else begin
			while (!$feof(fd) && n_lines < MAX_LINES) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%d %s %h %h %h", st_port[n_lines], st_op[n_lines],
						st_adr[n_lines], st_wdat[n_lines], st_exp[n_lines]);
					if (n == 5)
						n_lines++;
				end
			end
			$fclose(fd);
		end
		cycle_limit = n_lines * 20;

		@(negedge rst);
		for (i = 0; i < n_lines; i++) begin
			p = st_port[i];
			$sformat(name, "line %0d port %0d %s %h", i + 1, p, st_op[i], st_adr[i]);
			repeat ($urandom_range(3, 0)) @(posedge clk);
			@(posedge clk);
			#2;
			case (st_op[i])
			"W": begin
				run_access(p, 1'b1, st_adr[i], st_wdat[i], ACK_LIMIT, a1, r1, c1);
				check_true(name, a1, "write got no ack");
				if (st_adr[i] == GPIO_BASE + GPIO_OUT_OFS)
					check_value({name, " pins"}, st_wdat[i], gpio_out);
			end
			"R": begin
				run_access(p, 1'b0, st_adr[i], '0, ACK_LIMIT, a1, r1, c1);
				check_true(name, a1, "read got no ack");
				check_value(name, st_exp[i], r1);
			end
			"N": begin
				run_access(p, 1'b0, st_adr[i], '0, ACK_LIMIT, a1, r1, c1);
				check_true(name, !a1, "address outside the I/O range was acked");
			end
			"G": begin
				pins = bus_dat_t'($urandom());
				gpio_in = pins;
				// The pins pass a two-flop synchronizer first
				repeat (3) @(posedge clk);
				#2;
				run_access(p, 1'b0, GPIO_BASE + GPIO_IN_OFS, '0, ACK_LIMIT, a1, r1, c1);
				check_true(name, a1, "pin read got no ack");
				check_value(name, pins, r1);
			end
			"B": begin
				// Port 1 reads adr, port 2 reads adr + 1 at the same edge
				fork
					run_access(1, 1'b0, st_adr[i], '0, ACK_LIMIT, a1, r1, c1);
					run_access(2, 1'b0, st_adr[i] + 1, '0, 3 * ACK_LIMIT, a2, r2, c2);
				join
				check_true(name, a1 && a2, "a port of a shared request got no ack");
				check_true(name, c1 < c2, "port 2 was acked before port 1");
				check_value({name, " p1"}, st_exp[i], r1);
				check_value({name, " p2"}, st_wdat[i], r2);
			end
			"A": begin
				// Port 2 write waits behind port 1 and is dropped before service
				seen = 0;
				fork
					run_access(1, 1'b0, st_adr[i], '0, ACK_LIMIT, a1, r1, c1);
					begin
						drive_port(2, 1'b1, 1'b1, st_adr[i], st_wdat[i]);
						repeat (2) begin
							@(posedge clk);
							#1;
							seen |= s2_ack;
						end
						#1;
						drive_port(2, 1'b0, 1'b0, '0, '0);
						repeat (6) begin
							@(posedge clk);
							#1;
							seen |= s2_ack;
						end
						#1;
					end
				join
				check_true(name, a1, "port 1 read got no ack");
				check_value(name, st_exp[i], r1);
				check_true(name, !seen, "aborted port 2 write was acked");
			end
			default: begin
				check_true(name, 1'b0, "unknown operation in the stim file");
			end
			endcase
		end

		// Failures of the bound bridge properties count as well
		asserts_failed = dut0.u_bridge.u_bridge_asserts.fail_count;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, asserts_failed);
		if (errors == 0 && asserts_failed == 0 && n_lines > 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== tb/io_stim.txt ====
# port op addr wdata expect (hex); ops W write, R read, N outside range, G pin read,
# B both ports (p1 reads addr expecting expect, p2 reads addr+1 expecting wdata), A p2 abort
1 W E00000 11 00
1 W E00001 22 00
2 W E0000F A5 00
2 W E00002 3C 00
1 R E0000F 00 A5
2 R E00000 00 11
2 R E00001 00 22
1 W E00100 5A 00
2 R E00100 00 5A
1 G E00101 00 00
1 W E00101 77 00
1 R E00100 00 5A
1 N 001234 00 00
2 R E00002 00 3C
1 R E00200 00 FF
2 R E0F000 00 FF
1 B E00000 22 11
1 A E00002 99 3C
2 R E00002 00 3C
2 G E00101 00 00

// ==== flist.f ====
logic/bus_pkg.sv
logic/io_map_pkg.sv
logic/io_bridge.sv
logic/io_decoder.sv
logic/io_scratch_ram.sv
logic/io_gpio.sv
logic/io_subsys_top.sv
tb/tb_clkgen.sv
tb/io_bridge_asserts.sv
tb/io_subsys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= io_subsys_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
